// ==== tb.f ====
+incdir+.
inp_pkg.sv
inp_bus_if.sv
inp_sync.sv
inp_frame_timer.sv
inp_pause_fsm.sv
inp_joy_map.sv
inp_top.sv
inp_checker.sv
inp_tb.sv

// ==== inp_tb.sv ====
// testbench top for the input block with clock, reset, frame timing and a table of stimulus rows
`timescale 1ns/1ps
`default_nettype none

`include "inp_config.svh"

module inp_tb;

    localparam int ROWS = 27;

    typedef struct packed {
        logic [5:0] bj1;        // board joystick, player 1, low bits
        logic [5:0] kj1;        // keyboard joystick, player 1
        logic [5:0] bj2;        // board joystick, player 2
        logic [3:0] mode;       // rot_control, rot_ccw, en_4way, autofire_en
        logic [7:0] sys;        // coin, start, service, tilt, pause, reset
        logic       osd;
        logic [3:0] frames;
        logic [5:0] exp1;       // active high, before polarity
        logic [5:0] exp2;
        logic       exp_pause;
        logic [1:0] exp_rst;    // soft_rst pulses in the row
        logic [3:0] exp_fire;   // frames with button 0 seen pressed
    } row_t;

    logic clk, rst, vs, rot_control, rot_ccw, autofire_en, en_4way;
    logic [9:0] board_joy1, board_joy2, key_joy1, key_joy2;
    logic [1:0] board_coin, board_start, key_coin, key_start;
    logic key_service, key_tilt, key_pause, key_reset, osd_pause;
    logic [9:0] game_joy1, game_joy2;
    logic [1:0] game_coin, game_start;
    logic game_service, game_tilt, game_pause, soft_rst;

    logic [5:0]  phase;     // cycle inside the 64-cycle frame
    logic        start, done, fire_row;
    logic [9:0]  exp_joy1, exp_joy2;
    logic [5:0]  exp_sys;
    logic        exp_pause;
    logic [1:0]  exp_rst;
    logic [3:0]  exp_fire;
    logic [31:0] lfsr;
    row_t        rows [0:ROWS-1];
    int          n_rows, cycles, limit;

    inp_top u_inp_top (.*);

    inp_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk or posedge rst) begin
        if (rst) phase <= '0;
        else phase <= phase + 1'b1;
    end

    always @(posedge clk) begin
        #2 vs = (phase < 6'd8);     // sync high for 8 cycles of 64
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit != 0 && cycles > limit) begin
            $display("simulation timed out after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [3:0] rand_spare();
        logic [3:0] v;
        for (int i = 0; i < 4; i++) v[i] = rand_bit();
        return v;
    endfunction

    task automatic add_row(input logic [5:0] bj1, kj1, bj2, input logic [3:0] mode,
                           input logic [7:0] sys, input logic osd, input logic [3:0] frames,
                           input logic [5:0] exp1, exp2, input logic pause,
                           input logic [1:0] rst_n, input logic [3:0] fire);
        rows[n_rows] = {bj1, kj1, bj2, mode, sys, osd, frames, exp1, exp2, pause, rst_n, fire};
        n_rows = n_rows + 1;
    endtask

    task automatic apply_row(input row_t r);
        logic [3:0] sb1, sk1, sb2, sk2;
        sb1 = rand_spare();
        sk1 = rand_spare();
        sb2 = rand_spare();
        sk2 = rand_spare();
        board_joy1 = {sb1, r.bj1};
        key_joy1   = {sk1, r.kj1};
        board_joy2 = {sb2, r.bj2};
        key_joy2   = {sk2, 6'h00};
        {rot_control, rot_ccw, en_4way, autofire_en} = r.mode;
        board_coin = r.sys[7:6];
        key_start  = r.sys[5:4];
        {key_service, key_tilt, key_pause, key_reset} = r.sys[3:0];
        osd_pause  = r.osd;
        // merged by OR, then flipped to the game polarity
        exp_joy1  = {10{`INP_ACTIVE_LOW}} ^ {sb1 | sk1, r.exp1};
        exp_joy2  = {10{`INP_ACTIVE_LOW}} ^ {sb2 | sk2, r.exp2};
        exp_sys   = {6{`INP_ACTIVE_LOW}} ^ r.sys[7:2];
        exp_pause = r.exp_pause;
        exp_rst   = r.exp_rst;
        exp_fire  = r.exp_fire;
        fire_row  = r.mode[0];
    endtask

    initial begin
        {rst, vs, rot_control, rot_ccw, autofire_en, en_4way} = 6'b100000;
        {board_joy1, board_joy2, key_joy1, key_joy2} = '0;
        {board_coin, board_start, key_coin, key_start} = '0;
        {key_service, key_tilt, key_pause, key_reset, osd_pause} = '0;
        {start, done, fire_row, exp_pause, exp_rst, exp_fire} = '0;
        {exp_joy1, exp_joy2, exp_sys} = '0;
        lfsr = 32'h6d84;
        n_rows = 0;
        cycles = 0;
        limit = 0;
        add_row(6'h01, 6'h08, 6'h10, 4'b0000, 8'h6c, 0, 1, 6'h09, 6'h10, 0, 0, 0); // merge
        add_row(6'h20, 6'h10, 6'h00, 4'b0000, 8'h00, 0, 1, 6'h30, 6'h00, 0, 0, 1);
        add_row(6'h08, 6'h00, 6'h01, 4'b1000, 8'h00, 0, 1, 6'h01, 6'h04, 0, 0, 0); // cw
        add_row(6'h02, 6'h00, 6'h04, 4'b1000, 8'h00, 0, 1, 6'h08, 6'h02, 0, 0, 0);
        add_row(6'h08, 6'h00, 6'h01, 4'b1100, 8'h00, 0, 1, 6'h02, 6'h08, 0, 0, 0); // ccw
        add_row(6'h02, 6'h00, 6'h04, 4'b1100, 8'h00, 0, 1, 6'h04, 6'h01, 0, 0, 0);
        add_row(6'h0c, 6'h00, 6'h03, 4'b0000, 8'h00, 0, 1, 6'h04, 6'h01, 0, 0, 0);
        add_row(6'h08, 6'h00, 6'h04, 4'b0010, 8'h00, 0, 1, 6'h08, 6'h04, 0, 0, 0); // 4-way
        add_row(6'h09, 6'h00, 6'h06, 4'b0010, 8'h00, 0, 1, 6'h08, 6'h04, 0, 0, 0);
        add_row(6'h09, 6'h00, 6'h06, 4'b0000, 8'h00, 0, 1, 6'h09, 6'h06, 0, 0, 0);
        add_row(6'h10, 6'h00, 6'h00, 4'b0001, 8'h00, 0, 8, 6'h10, 6'h00, 0, 0, 2); // autofire
        add_row(6'h10, 6'h00, 6'h00, 4'b0000, 8'h00, 0, 8, 6'h10, 6'h00, 0, 0, 8);
        add_row(6'h00, 6'h00, 6'h00, 4'b0000, 8'h02, 0, 1, 6'h00, 6'h00, 1, 0, 0); // pause
        add_row(6'h00, 6'h00, 6'h00, 4'b0000, 8'h00, 0, 1, 6'h00, 6'h00, 1, 0, 0);
        add_row(6'h00, 6'h00, 6'h00, 4'b0000, 8'h08, 0, 1, 6'h00, 6'h00, 0, 0, 0); // step
        add_row(6'h00, 6'h00, 6'h00, 4'b0000, 8'h00, 0, 1, 6'h00, 6'h00, 1, 0, 0);
        add_row(6'h00, 6'h00, 6'h00, 4'b0000, 8'h02, 0, 1, 6'h00, 6'h00, 0, 0, 0);
        add_row(6'h00, 6'h00, 6'h00, 4'b0000, 8'h00, 0, 1, 6'h00, 6'h00, 0, 0, 0);
        add_row(6'h00, 6'h00, 6'h00, 4'b0000, 8'h00, 1, 1, 6'h00, 6'h00, 1, 0, 0); // menu
        add_row(6'h00, 6'h00, 6'h00, 4'b0000, 8'h02, 1, 1, 6'h00, 6'h00, 0, 0, 0);
        add_row(6'h00, 6'h00, 6'h00, 4'b0000, 8'h00, 0, 1, 6'h00, 6'h00, 0, 0, 0);
        add_row(6'h00, 6'h00, 6'h00, 4'b0000, 8'h02, 0, 1, 6'h00, 6'h00, 1, 0, 0);
        add_row(6'h00, 6'h00, 6'h00, 4'b0000, 8'h00, 1, 1, 6'h00, 6'h00, 1, 0, 0);
        add_row(6'h00, 6'h00, 6'h00, 4'b0000, 8'h00, 0, 1, 6'h00, 6'h00, 0, 0, 0);
        add_row(6'h00, 6'h00, 6'h00, 4'b0000, 8'h01, 0, 1, 6'h00, 6'h00, 0, 1, 0); // reset
        add_row(6'h00, 6'h00, 6'h00, 4'b0000, 8'h00, 0, 1, 6'h00, 6'h00, 0, 0, 0);
        add_row(6'h00, 6'h00, 6'h00, 4'b0000, 8'h01, 0, 1, 6'h00, 6'h00, 0, 1, 0);
        for (int i = 0; i < n_rows; i++) limit = limit + rows[i].frames * 64;
        limit = limit + 400;    // reset, alignment and slack
        repeat (2) @(posedge clk);
        #2 rst = 1'b0;
        @(negedge clk);
        while (phase != 6'd15) @(negedge clk);
        @(posedge clk);
        for (int i = 0; i < n_rows; i++) begin
            #2 done = 1'b0;
            apply_row(rows[i]);
            start = 1'b1;
            @(posedge clk);
            #2 start = 1'b0;
            repeat (rows[i].frames * 64 - 2) @(posedge clk);
            #2 done = 1'b1;
            @(posedge clk);
        end
        #2 done = 1'b0;
        @(posedge clk);
        $display("tests run %0d, errors %0d", u_checker.tests, u_checker.errors);
        if (u_checker.errors == 0 && u_checker.tests == n_rows) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== inp_checker.sv ====
// testbench monitor that compares the input block outputs with each row's expected values
`timescale 1ns/1ps
`default_nettype none

`include "inp_config.svh"

module inp_checker (
    input wire logic       clk,
    input wire logic [5:0] phase,
    input wire logic       start,
    input wire logic       done,
    input wire logic       fire_row,
    input wire logic [9:0] exp_joy1,
    input wire logic [9:0] exp_joy2,
    input wire logic [5:0] exp_sys,
    input wire logic       exp_pause,
    input wire logic [1:0] exp_rst,
    input wire logic [3:0] exp_fire,
    input wire logic [9:0] game_joy1,
    input wire logic [9:0] game_joy2,
    input wire logic [1:0] game_coin,
    input wire logic [1:0] game_start,
    input wire logic       game_service,
    input wire logic       game_tilt,
    input wire logic       game_pause,
    input wire logic       soft_rst
);

    int         tests = 0;
    int         errors = 0;
    int         cnt, rst_seen, fire_seen;
    logic       row_bad;
    logic       in_row = 1'b0;     // set once the first row starts
    logic [9:0] mask;

    task automatic flag(input string msg);
        $display("Error at %0t: %s", $time, msg);
        errors = errors + 1;
        row_bad = 1'b1;
    endtask

    always @(negedge clk) begin
        if (start) begin
            {cnt, rst_seen, fire_seen, row_bad} = '0;
            in_row = 1'b1;
        end else begin
            cnt = cnt + 1;
        end
        if (soft_rst) rst_seen = rst_seen + 1;
        if (phase == 6'd32 && game_joy1[4] != `INP_ACTIVE_LOW) fire_seen = fire_seen + 1;
        if (in_row && cnt == 10) begin
            mask = fire_row ? 10'h3ef : 10'h3ff;    // button 0 follows the frame count
            if ((game_joy1 & mask) != (exp_joy1 & mask))
                flag($sformatf("game_joy1 %h, expected %h", game_joy1, exp_joy1));
            if ((game_joy2 & mask) != (exp_joy2 & mask))
                flag($sformatf("game_joy2 %h, expected %h", game_joy2, exp_joy2));
            if ({game_coin, game_start, game_service, game_tilt} != exp_sys)
                flag($sformatf("system keys %b, expected %b",
                               {game_coin, game_start, game_service, game_tilt}, exp_sys));
            if (game_pause != exp_pause)
                flag($sformatf("game_pause %b, expected %b", game_pause, exp_pause));
        end
        if (done) begin
            if (rst_seen != exp_rst)
                flag($sformatf("%0d soft_rst pulses, expected %0d", rst_seen, exp_rst));
            if (fire_seen != exp_fire)
                flag($sformatf("button 0 in %0d frames, expected %0d", fire_seen, exp_fire));
            $display("test %0d %s", tests, row_bad ? "failed" : "passed");
            tests = tests + 1;
        end
    end

endmodule

`default_nettype wire

// ==== inp_top.sv ====
// input block top, from board and keyboard controls to the game-side signals
`timescale 1ns/1ps
`default_nettype none

module inp_top import inp_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       vs,
    input  wire logic       rot_control,
    input  wire logic       rot_ccw,
    input  wire logic       autofire_en,
    input  wire logic       en_4way,
    input  wire logic [9:0] board_joy1,
    input  wire logic [9:0] board_joy2,
    input  wire logic [9:0] key_joy1,
    input  wire logic [9:0] key_joy2,
    input  wire logic [1:0] board_coin,
    input  wire logic [1:0] board_start,
    input  wire logic [1:0] key_coin,
    input  wire logic [1:0] key_start,
    input  wire logic       key_service,
    input  wire logic       key_tilt,
    input  wire logic       key_pause,
    input  wire logic       key_reset,
    input  wire logic       osd_pause,
    output logic      [9:0] game_joy1,
    output logic      [9:0] game_joy2,
    output logic      [1:0] game_coin,
    output logic      [1:0] game_start,
    output logic            game_service,
    output logic            game_tilt,
    output logic            game_pause,
    output logic            soft_rst
);

    inp_bus_if bus();

    logic       vbl_in, vbl_out;
    logic       autofire;
    logic [1:0] misc_s;     // osd_pause and vs after the synchronizer

    inp_sync #(.T(joy_pair_t)) u_sync_joy (
        .clk   ( clk                                    ),
        .rst   ( rst                                    ),
        .board ( joy_pair_t'({board_joy1, board_joy2})  ),
        .key   ( joy_pair_t'({key_joy1, key_joy2})      ),
        .sync  ( bus.joy                                )
    );

    // service, tilt, pause and reset only come from the keyboard
    inp_sync #(.T(sys_t)) u_sync_sys (
        .clk   ( clk                                              ),
        .rst   ( rst                                              ),
        .board ( sys_t'({board_coin, board_start, 4'b0000})       ),
        .key   ( sys_t'({key_coin, key_start, key_service,
                         key_tilt, key_pause, key_reset})         ),
        .sync  ( bus.sys                                          )
    );

    inp_sync #(.T(logic [1:0])) u_sync_misc (
        .clk   ( clk               ),
        .rst   ( rst               ),
        .board ( 2'b00             ),
        .key   ( {osd_pause, vs}   ),
        .sync  ( misc_s            )
    );

    assign bus.osd_pause = misc_s[1];
    assign bus.vs_s      = misc_s[0];

    inp_frame_timer u_frame_timer (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .autofire_en ( autofire_en ),
        .bus         ( bus         ),
        .vbl_in      ( vbl_in      ),
        .vbl_out     ( vbl_out     ),
        .autofire    ( autofire    )
    );

    inp_pause_fsm u_pause_fsm (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .vbl_out      ( vbl_out      ),
        .bus          ( bus          ),
        .game_pause   ( game_pause   ),
        .soft_rst     ( soft_rst     ),
        .game_service ( game_service ),
        .game_tilt    ( game_tilt    ),
        .game_coin    ( game_coin    ),
        .game_start   ( game_start   )
    );

    inp_joy_map u_map_1p (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .en_4way     ( en_4way     ),
        .rot_control ( rot_control ),
        .rot_ccw     ( rot_ccw     ),
        .autofire    ( autofire    ),
        .joy_in      ( bus.joy.p1  ),
        .game_joy    ( game_joy1   )
    );

    inp_joy_map u_map_2p (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .en_4way     ( en_4way     ),
        .rot_control ( rot_control ),
        .rot_ccw     ( rot_ccw     ),
        .autofire    ( autofire    ),
        .joy_in      ( bus.joy.p2  ),
        .game_joy    ( game_joy2   )
    );

endmodule

`default_nettype wire

// ==== inp_joy_map.sv ====
// one player's joystick path from the synchronized inputs to the game-side port
`timescale 1ns/1ps
`default_nettype none

`include "inp_config.svh"

module inp_joy_map import inp_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  en_4way,
    input  wire logic  rot_control,
    input  wire logic  rot_ccw,
    input  wire logic  autofire,
    input  wire joy_t  joy_in,
    output logic [9:0] game_joy
);

    logic [3:0]              dirs;       // raw directions
    logic [3:0]              last_dir;   // last single direction seen
    logic [3:0]              dir_4w;     // after the 4-way filter
    logic [3:0]              dir_rot;
    logic [3:0]              dir_out;
    logic [`INP_BUTTONS-1:0] live_btn;
    joy_t                    mapped;

    assign dirs = joy_in[JOY_UP:JOY_RIGHT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_dir <= '0;
        end else if ($onehot(dirs)) begin
            last_dir <= dirs;
        end
    end

    // diagonals keep the previous direction on 4-way games
    assign dir_4w = (en_4way && !$onehot0(dirs)) ? last_dir : dirs;

    always_comb begin
        dir_rot = dir_4w;
        if (rot_control) begin
            if (rot_ccw) begin
                dir_rot[JOY_UP]    = dir_4w[JOY_RIGHT];
                dir_rot[JOY_DOWN]  = dir_4w[JOY_LEFT];
                dir_rot[JOY_LEFT]  = dir_4w[JOY_UP];
                dir_rot[JOY_RIGHT] = dir_4w[JOY_DOWN];
            end else begin
                dir_rot[JOY_UP]    = dir_4w[JOY_LEFT];
                dir_rot[JOY_DOWN]  = dir_4w[JOY_RIGHT];
                dir_rot[JOY_LEFT]  = dir_4w[JOY_DOWN];
                dir_rot[JOY_RIGHT] = dir_4w[JOY_UP];
            end
        end
    end

    always_comb begin
        dir_out = dir_rot;
        if (dir_rot[JOY_UP] && dir_rot[JOY_DOWN]) dir_out[JOY_UP] = 1'b0;       // down wins
        if (dir_rot[JOY_LEFT] && dir_rot[JOY_RIGHT]) dir_out[JOY_LEFT] = 1'b0;  // right wins
    end

    always_comb begin
        live_btn    = joy_in[JOY_BTN_LAST:JOY_B0];
        live_btn[0] = joy_in[JOY_B0] & autofire;    // gated by frame count
        mapped      = {joy_in[JOY_BITS-1:JOY_BTN_LAST+1], live_btn, dir_out};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_joy <= {JOY_BITS{`INP_ACTIVE_LOW}};
        end else begin
            game_joy <= {JOY_BITS{`INP_ACTIVE_LOW}} ^ mapped;
        end
    end

endmodule

`default_nettype wire

// ==== inp_pause_fsm.sv ====
// pause state machine with menu override and frame stepping, plus system-key outputs
`timescale 1ns/1ps
`default_nettype none

`include "inp_config.svh"

module inp_pause_fsm import inp_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  vbl_out,
    inp_bus_if.sink    bus,
    output logic       game_pause,
    output logic       soft_rst,
    output logic       game_service,
    output logic       game_tilt,
    output logic [1:0] game_coin,
    output logic [1:0] game_start
);

    pause_state_t state, state_nx;

    logic pause_l, service_l, reset_l, osd_l;   // previous levels
    logic pause_up, service_up, reset_up;       // registered rising edges
    logic osd_chg;                              // menu opened or closed

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pause_l    <= 1'b0;
            service_l  <= 1'b0;
            reset_l    <= 1'b0;
            osd_l      <= 1'b0;
            pause_up   <= 1'b0;
            service_up <= 1'b0;
            reset_up   <= 1'b0;
            osd_chg    <= 1'b0;
        end else begin
            pause_l    <= bus.sys.pause;
            service_l  <= bus.sys.service;
            reset_l    <= bus.sys.reset;
            osd_l      <= bus.osd_pause;
            pause_up   <= bus.sys.pause & ~pause_l;
            service_up <= bus.sys.service & ~service_l;
            reset_up   <= bus.sys.reset & ~reset_l;
            osd_chg    <= bus.osd_pause ^ osd_l;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            RUN:     if (pause_up) state_nx = PAUSED;
            PAUSED: begin
                if (pause_up) begin
                    state_nx = RUN;
                end else if (service_up) begin
                    state_nx = STEP;    // let one frame through
                end
            end
            STEP:    if (vbl_out) state_nx = PAUSED;
            default: state_nx = RUN;
        endcase
        // the menu wins over the keys
        if (osd_chg) state_nx = osd_l ? PAUSED : RUN;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= RUN;
            soft_rst     <= 1'b0;
            game_coin    <= {2{`INP_ACTIVE_LOW}};
            game_start   <= {2{`INP_ACTIVE_LOW}};
            game_service <= `INP_ACTIVE_LOW;
            game_tilt    <= `INP_ACTIVE_LOW;
        end else begin
            state        <= state_nx;
            soft_rst     <= reset_up;   // one cycle per press
            game_coin    <= {2{`INP_ACTIVE_LOW}} ^ bus.sys.coin;
            game_start   <= {2{`INP_ACTIVE_LOW}} ^ bus.sys.start;
            game_service <= `INP_ACTIVE_LOW ^ bus.sys.service;
            game_tilt    <= `INP_ACTIVE_LOW ^ bus.sys.tilt;
        end
    end

    assign game_pause = (state == PAUSED);  // STEP runs the game

endmodule

`default_nettype wire

// ==== inp_frame_timer.sv ====
// vertical sync edge pulses and the frame-locked autofire gate for button 0
`timescale 1ns/1ps
`default_nettype none

`include "inp_config.svh"

module inp_frame_timer (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic autofire_en,
    inp_bus_if.sink   bus,
    output logic      vbl_in,
    output logic      vbl_out,
    output logic      autofire
);

    logic                      vs_l;       // vs_s one cycle back
    logic [`INP_FIRE_BITS-1:0] fire_cnt;   // frames seen, wraps

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vs_l    <= 1'b0;
            vbl_in  <= 1'b0;
            vbl_out <= 1'b0;
        end else begin
            vs_l    <= bus.vs_s;
            vbl_in  <= bus.vs_s & ~vs_l;    // blank starts
            vbl_out <= ~bus.vs_s & vs_l;    // blank ends
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fire_cnt <= '0;
        end else if (vbl_in) begin
            fire_cnt <= fire_cnt + 1'b1;
        end
    end

    // open for the top two counts only, so two frames in eight
    assign autofire = !autofire_en || (&fire_cnt[`INP_FIRE_BITS-1:1]);

endmodule

`default_nettype wire

// ==== inp_sync.sv ====
// merges board and keyboard copies of one payload and brings it into the clk domain
`timescale 1ns/1ps
`default_nettype none

module inp_sync import inp_pkg::*; #(
    parameter type T = joy_pair_t
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire T     board,
    input  wire T     key,
    output T          sync
);

    T meta;     // first stage, may go metastable

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            meta <= '0;
            sync <= '0;
        end else begin
            meta <= board | key;    // either source presses the control
            sync <= meta;
        end
    end

endmodule

`default_nettype wire

// ==== inp_bus_if.sv ====
// bundle of synchronized player and system inputs passed between the input block modules
`timescale 1ns/1ps
`default_nettype none

interface inp_bus_if import inp_pkg::*; ();

    joy_pair_t joy;         // both players, merged board and keyboard
    sys_t      sys;         // coin, start and the control keys
    logic      osd_pause;   // menu open on the on-screen display
    logic      vs_s;        // vertical sync after the synchronizer

    // driven from the synchronizer outputs
    modport source (
        output joy,
        output sys,
        output osd_pause,
        output vs_s
    );

    // read by the timer and the pause machine
    modport sink (
        input joy,
        input sys,
        input osd_pause,
        input vs_s
    );

endinterface

`default_nettype wire

// ==== inp_pkg.sv ====
// shared joystick, system-key and pause-state types, imported by the input block modules
`default_nettype none

`include "inp_config.svh"

package inp_pkg;

    localparam int JOY_BITS = 10;

    // direction and button bit positions inside joy_t
    localparam int JOY_RIGHT = 0;
    localparam int JOY_LEFT  = 1;
    localparam int JOY_DOWN  = 2;
    localparam int JOY_UP    = 3;
    localparam int JOY_B0    = 4;

    // highest live button bit, spares sit above it
    localparam int JOY_BTN_LAST = JOY_B0 + `INP_BUTTONS - 1;

    // one player, active high inside the design
    typedef logic [JOY_BITS-1:0] joy_t;

    typedef struct packed {
        joy_t p1;
        joy_t p2;
    } joy_pair_t;

    // system keys, coin and start are per player
    typedef struct packed {
        logic [1:0] coin;
        logic [1:0] start;
        logic       service;
        logic       tilt;
        logic       pause;
        logic       reset;
    } sys_t;

    typedef enum logic [1:0] {
        RUN    = 2'd0,
        PAUSED = 2'd1,
        STEP   = 2'd2     // running until the next blank ends
    } pause_state_t;

endpackage

`default_nettype wire

// ==== inp_config.svh ====
// build-time settings for the input block, included by the package and the RTL modules
`ifndef INP_CONFIG_SVH
`define INP_CONFIG_SVH

// game side wants active-low controls when set
`define INP_ACTIVE_LOW 1'b1

// live buttons per player, the rest are spares
`define INP_BUTTONS 2

// autofire frame counter width
`define INP_FIRE_BITS 3

`endif
